// File: compile.f
+incdir+include
hdl/cpuPkg.sv
hdl/ctrlIf.sv
hdl/control.sv
hdl/alu.sv
hdl/regFile.sv
hdl/pcUnit.sv
hdl/mipsCore.sv
verification/mipsCoreTb.sv

// File: hdl/alu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu
(
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    input  cpuPkg::aluOpT aluOp,
    output cpuPkg::wordT  result,
    output logic          zero
);

    always_comb
    begin
        case (aluOp)
            `ALU_ADD:
            begin
                result = a + b;
            end
            `ALU_SUB:
            begin
                result = a - b;
            end
            `ALU_XOR:
            begin
                result = a ^ b;
            end
            `ALU_SLT:
            begin
                // signed compare, so negative operands order correctly
                result = ($signed(a) < $signed(b)) ? cpuPkg::wordT'(1) : '0;
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0); // bne branches when this is low

endmodule

// File: hdl/control.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module control
(
    input  cpuPkg::opcodeT opp,
    input  cpuPkg::functT  func,
    ctrlIf.decoder         ctrl
);

    always_comb
    begin
        // anything not matched below retires as a no-op
        ctrl.regDst   = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memtoReg = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.link     = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.jumpReg  = 1'b0;
        ctrl.aluOp    = `ALU_ADD;

        case (opp)
            `OP_JUMP:
            begin
                ctrl.jump = 1'b1;
            end
            `OP_JAL:
            begin
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.link     = 1'b1; // r31 gets pc+4
            end
            `OP_LW:
            begin
                ctrl.aluSrc   = 1'b1; // address is rs plus the immediate
                ctrl.memRead  = 1'b1;
                ctrl.memtoReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_SW:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            `OP_BNE:
            begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = `ALU_SUB; // zero flag tells whether rs equals rt
            end
            `OP_XORI:
            begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = `ALU_XOR;
            end
            `OP_RTYPE:
            begin
                case (func)
                    `FN_JR:
                    begin
                        ctrl.jumpReg = 1'b1;
                    end
                    `FN_ADD:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = `ALU_ADD;
                    end
                    `FN_SUB:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = `ALU_SUB;
                    end
                    `FN_SLT:
                    begin
                        ctrl.regDst   = 1'b1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = `ALU_SLT;
                    end
                    default:
                    begin
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            default:
            begin
                ctrl.regWrite = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/cpuPkg.sv
`include "cpu_settings.svh"

package cpuPkg;

    // data words and byte addresses share one width
    typedef logic [`DATA_WIDTH-1:0] wordT;

    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

    // instruction fields
    typedef logic [`OPCODE_WIDTH-1:0] opcodeT;
    typedef logic [`FUNCT_WIDTH-1:0] functT;

    typedef logic [`ALU_OP_WIDTH-1:0] aluOpT; // see the ALU_* codes

endpackage

// File: hdl/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;

    logic regDst;
    logic aluSrc;
    logic memtoReg;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic link;
    logic jump;
    logic branch;
    logic jumpReg;
    cpuPkg::aluOpT aluOp;

    modport decoder (output regDst, aluSrc, memtoReg, regWrite, memRead, memWrite, link,
        jump, branch, jumpReg, aluOp);

    // operand muxes, writeback and the data memory strobes
    modport datapath (input regDst, aluSrc, memtoReg, regWrite, memRead, memWrite, link,
        aluOp);

    modport sequencer (input jump, branch, jumpReg); // next pc selection only

endinterface

// File: hdl/mipsCore.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mipsCore
(
    input  logic         clk,
    input  logic         arstN,
    output cpuPkg::wordT instrAddr,
    input  cpuPkg::wordT instr,
    output cpuPkg::wordT memAddr,
    output cpuPkg::wordT memWData,
    input  cpuPkg::wordT memRData,
    output logic         memRead,
    output logic         memWrite
);

    cpuPkg::opcodeT  opcode;
    cpuPkg::functT   funct;
    cpuPkg::regAddrT rs;
    cpuPkg::regAddrT rt;
    cpuPkg::regAddrT rd;
    cpuPkg::wordT    signExtImm;
    cpuPkg::wordT    rsData;
    cpuPkg::wordT    rtData;
    cpuPkg::wordT    aluB;
    cpuPkg::wordT    aluResult;
    logic            aluZero;
    cpuPkg::regAddrT writeAddr;
    cpuPkg::wordT    writeData;
    cpuPkg::wordT    pc;
    cpuPkg::wordT    pcPlus4;

    ctrlIf ctrlBus ();

    // instruction fields, shamt is not used by any supported opcode
    assign opcode     = instr[31:26];
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign rd         = instr[15:11];
    assign funct      = instr[5:0];
    assign signExtImm = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};

    control u_control
    (
        .opp  (opcode),
        .func (funct),
        .ctrl (ctrlBus.decoder)
    );

    regFile u_regFile
    (
        .clk         (clk),
        .arstN       (arstN),
        .readAddrA   (rs),
        .readAddrB   (rt),
        .readDataA   (rsData),
        .readDataB   (rtData),
        .writeEnable (ctrlBus.regWrite),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

    assign aluB = ctrlBus.aluSrc ? signExtImm : rtData;

    alu u_alu
    (
        .a      (rsData),
        .b      (aluB),
        .aluOp  (ctrlBus.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    pcUnit u_pcUnit
    (
        .clk          (clk),
        .arstN        (arstN),
        .ctrl         (ctrlBus.sequencer),
        .zero         (aluZero),
        .branchOffset (signExtImm),
        .jumpIndex    (instr[`JUMP_INDEX_WIDTH-1:0]),
        .jumpTarget   (rsData),
        .pc           (pc),
        .pcPlus4      (pcPlus4)
    );

    // link wins over regDst so jal always lands in r31
    assign writeAddr = ctrlBus.link ? `LINK_REG : (ctrlBus.regDst ? rd : rt);

    assign writeData = ctrlBus.link     ? pcPlus4 :
                       ctrlBus.memtoReg ? memRData : aluResult;

    assign instrAddr = pc;
    assign memAddr   = aluResult; // lw and sw compute rs plus the immediate
    assign memWData  = rtData;
    assign memRead   = ctrlBus.memRead;
    assign memWrite  = ctrlBus.memWrite;

endmodule

// File: hdl/pcUnit.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module pcUnit
(
    input  logic                          clk,
    input  logic                          arstN,
    ctrlIf.sequencer                      ctrl,
    input  logic                          zero,
    input  cpuPkg::wordT                  branchOffset,
    input  logic [`JUMP_INDEX_WIDTH-1:0]  jumpIndex,
    input  cpuPkg::wordT                  jumpTarget,
    output cpuPkg::wordT                  pc,
    output cpuPkg::wordT                  pcPlus4
);

    cpuPkg::wordT nextPc;

    assign pcPlus4 = pc + cpuPkg::wordT'(4);

    always_comb
    begin
        if (ctrl.jumpReg)
        begin
            nextPc = jumpTarget; // rs value
        end
        else if (ctrl.jump)
        begin
            nextPc = {pcPlus4[`DATA_WIDTH-1:`JUMP_INDEX_WIDTH+2], jumpIndex, 2'b00};
        end
        else if (ctrl.branch && !zero)
        begin
            nextPc = pcPlus4 + (branchOffset << 2); // bne taken
        end
        else
        begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pc <= `RESET_PC;
        end
        else
        begin
            pc <= nextPc;
        end
    end

    // the decoder must never ask for two kinds of redirect at once
    oneRedirect: assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({ctrl.jump, ctrl.jumpReg, ctrl.branch}))
        else $error("more than one of jump, jumpReg and branch is high");

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

endmodule

// File: hdl/regFile.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regFile
(
    input  logic            clk,
    input  logic            arstN,
    input  cpuPkg::regAddrT readAddrA,
    input  cpuPkg::regAddrT readAddrB,
    output cpuPkg::wordT    readDataA,
    output cpuPkg::wordT    readDataB,
    input  logic            writeEnable,
    input  cpuPkg::regAddrT writeAddr,
    input  cpuPkg::wordT    writeData
);

    cpuPkg::wordT regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEnable && writeAddr != '0) // r0 is hardwired
        begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    // an unknown here means the datapath fed X into writeback
    writeKnown: assert property (@(posedge clk) disable iff (!arstN)
        writeEnable && writeAddr != '0 |=> !$isunknown(regs[$past(writeAddr)]))
        else $error("register r%0d became unknown after a write", $past(writeAddr));

endmodule

// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath widths
`define DATA_WIDTH       32
`define REG_ADDR_WIDTH   5
`define REG_COUNT        (1 << `REG_ADDR_WIDTH)
`define OPCODE_WIDTH     6
`define FUNCT_WIDTH      6
`define ALU_OP_WIDTH     3
`define JUMP_INDEX_WIDTH 26

`define RESET_PC         32'h0000_0000
`define LINK_REG         5'd31 // jal writes the return address here

`define OP_JUMP          6'h02
`define OP_JAL           6'h03
`define OP_BNE           6'h05
`define OP_XORI          6'h0e
`define OP_LW            6'h23
`define OP_SW            6'h2b
`define OP_RTYPE         6'h00

`define FN_JR            6'h08
`define FN_ADD           6'h20
`define FN_SUB           6'h22
`define FN_SLT           6'h2a

`define ALU_ADD          3'd0
`define ALU_SUB          3'd1
`define ALU_XOR          3'd6
`define ALU_SLT          3'd7

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, then judge the run from its log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module mipsCoreTb -o simv \
    > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "Result: PASSED" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: verification/mipsCoreTb.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module mipsCoreTb;

    localparam int CYCLE_LIMIT = 200; // about 30 executed instructions plus reset
    localparam cpuPkg::wordT HALT_ADDR = 32'h70;

    logic clk = 1'b0;
    logic arstN;
    cpuPkg::wordT instrAddr, instr, memAddr, memWData, memRData;
    logic memRead, memWrite;
    cpuPkg::wordT imem [64];
    cpuPkg::wordT dmem [64];
    cpuPkg::wordT refMem [64];
    cpuPkg::wordT refRegs [32];
    cpuPkg::wordT refPc, refInstr, refRs, refRt, refImm, refPlus4;
    cpuPkg::wordT expNextPc, expAddr, expWData, expWrData;
    cpuPkg::regAddrT expWrAddr;
    logic expWrEn;
    logic [31:0] seed = 32'h55a1;
    int errors = 0;
    int cycles = 0;

    mipsCore u_mipsCore (.clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
        .memAddr(memAddr), .memWData(memWData), .memRData(memRData), .memRead(memRead),
        .memWrite(memWrite));

    initial
    begin
        forever #2 clk = ~clk;
    end

    // a zero word is fed while in reset so the core sees a no-op
    assign instr    = arstN ? imem[instrAddr[7:2]] : '0;
    assign memRData = dmem[memAddr[7:2]];

    always @(posedge clk)
    begin
        if (memWrite)
            dmem[memAddr[7:2]] <= memWData;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic cpuPkg::wordT signExt(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic cpuPkg::wordT encodeI(input cpuPkg::opcodeT op, input cpuPkg::regAddrT rs,
        input cpuPkg::regAddrT rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpuPkg::wordT encodeR(input cpuPkg::regAddrT rs, input cpuPkg::regAddrT rt,
        input cpuPkg::regAddrT rd, input cpuPkg::functT fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic cpuPkg::wordT encodeJ(input cpuPkg::opcodeT op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    function automatic logic changesFlow(input cpuPkg::wordT w);
        return w[31:26] == `OP_JUMP || w[31:26] == `OP_JAL || w[31:26] == `OP_BNE
            || (w[31:26] == `OP_RTYPE && w[5:0] == `FN_JR);
    endfunction

    function automatic logic isUnknownOp(input cpuPkg::wordT w);
        return !(w[31:26] inside {`OP_JUMP, `OP_JAL, `OP_BNE, `OP_XORI, `OP_LW, `OP_SW,
            `OP_RTYPE});
    endfunction

    task automatic reportMismatch(input string name, input cpuPkg::wordT exp,
        input cpuPkg::wordT act);
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 64; i++)
        begin
            seed = lcgNext(seed);
            imem[i] = '0;
            dmem[i] = seed;
            refMem[i] = seed;
        end
        seed = lcgNext(seed);
        imem[0] = encodeI(`OP_XORI, 5'd0, 5'd1, seed[15:0]);
        seed = lcgNext(seed);
        imem[1] = encodeI(`OP_XORI, 5'd0, 5'd2, seed[15:0]);
        imem[2] = encodeI(`OP_XORI, 5'd0, 5'd3, 16'h8005); // negative after extension
        imem[3] = encodeI(`OP_XORI, 5'd0, 5'd4, 16'h8100);
        imem[4] = encodeR(5'd1, 5'd2, 5'd5, `FN_ADD);
        imem[5] = encodeR(5'd1, 5'd2, 5'd6, `FN_SUB);
        imem[6] = encodeR(5'd3, 5'd4, 5'd7, `FN_SLT);
        imem[7] = encodeR(5'd4, 5'd3, 5'd8, `FN_SLT);
        imem[8] = encodeR(5'd3, 5'd1, 5'd9, `FN_SLT);
        imem[9] = encodeI(`OP_SW, 5'd0, 5'd5, 16'h40);
        imem[10] = encodeI(`OP_SW, 5'd0, 5'd6, 16'h44);
        imem[11] = encodeI(`OP_SW, 5'd0, 5'd7, 16'h48);
        imem[12] = encodeI(`OP_SW, 5'd0, 5'd8, 16'h4c);
        imem[13] = encodeI(`OP_SW, 5'd0, 5'd9, 16'h50);
        imem[14] = encodeI(`OP_SW, 5'd0, 5'd1, 16'h54);
        imem[15] = encodeI(`OP_LW, 5'd0, 5'd10, 16'h80);
        imem[16] = encodeI(`OP_LW, 5'd0, 5'd11, 16'h84);
        imem[17] = encodeI(`OP_SW, 5'd0, 5'd10, 16'h58);
        imem[18] = encodeI(`OP_SW, 5'd0, 5'd11, 16'h5c);
        imem[19] = encodeI(`OP_BNE, 5'd10, 5'd10, 16'd5); // equal operands, falls through
        imem[20] = encodeI(`OP_BNE, 5'd3, 5'd0, 16'd1);
        imem[21] = encodeI(`OP_XORI, 5'd0, 5'd12, 16'h1); // skipped by the taken branch
        imem[22] = encodeI(`OP_SW, 5'd0, 5'd12, 16'h60);
        imem[23] = encodeJ(`OP_JUMP, 26'd25);
        imem[24] = encodeI(`OP_XORI, 5'd0, 5'd13, 16'h7);
        imem[25] = encodeJ(`OP_JAL, 26'd30);
        imem[26] = encodeI(`OP_SW, 5'd0, 5'd31, 16'h64);
        imem[27] = 32'hfc00_0000;
        imem[28] = encodeJ(`OP_JUMP, 26'd28); // halt loop
        imem[30] = encodeI(`OP_SW, 5'd0, 5'd31, 16'h68);
        imem[31] = encodeR(5'd31, 5'd0, 5'd0, `FN_JR);
    endtask

    // reference model, stepped on the same edge as the core
    always_comb
    begin
        refInstr  = imem[refPc[7:2]];
        refRs     = refRegs[refInstr[25:21]];
        refRt     = refRegs[refInstr[20:16]];
        refImm    = signExt(refInstr[15:0]);
        refPlus4  = refPc + 32'd4;
        expAddr   = refRs + refImm;
        expWData  = refRt;
        expNextPc = refPlus4;
        expWrEn   = 1'b0;
        expWrAddr = refInstr[20:16];
        expWrData = '0;
        case (refInstr[31:26])
            `OP_JUMP: expNextPc = {refPlus4[31:28], refInstr[25:0], 2'b00};
            `OP_JAL:
            begin
                expNextPc = {refPlus4[31:28], refInstr[25:0], 2'b00};
                expWrEn   = 1'b1;
                expWrAddr = 5'd31;
                expWrData = refPlus4;
            end
            `OP_LW:
            begin
                expWrEn   = 1'b1;
                expWrData = refMem[expAddr[7:2]];
            end
            `OP_BNE:
            begin
                if (refRs != refRt)
                    expNextPc = refPlus4 + (refImm << 2);
            end
            `OP_XORI:
            begin
                expWrEn   = 1'b1;
                expWrData = refRs ^ refImm;
            end
            `OP_RTYPE:
            begin
                expWrAddr = refInstr[15:11];
                expWrEn   = refInstr[5:0] inside {`FN_ADD, `FN_SUB, `FN_SLT};
                case (refInstr[5:0])
                    `FN_JR:  expNextPc = refRs;
                    `FN_ADD: expWrData = refRs + refRt;
                    `FN_SUB: expWrData = refRs - refRt;
                    `FN_SLT: expWrData = ($signed(refRs) < $signed(refRt)) ? 32'd1 : 32'd0;
                    default: expWrEn = 1'b0;
                endcase
            end
            default: expWrEn = 1'b0;
        endcase
    end

    always @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            refPc <= `RESET_PC;
            for (int i = 0; i < 32; i++)
                refRegs[i] <= '0;
        end
        else
        begin
            refPc <= expNextPc;
            if (expWrEn && expWrAddr != '0)
                refRegs[expWrAddr] <= expWrData;
            if (refInstr[31:26] == `OP_SW)
                refMem[expAddr[7:2]] <= expWData;
        end
    end

    resetState: assert property (@(posedge clk) (!arstN || $rose(arstN))
        |-> instrAddr == '0 && !memRead && !memWrite)
        else reportMismatch("resetState", '0, $sampled(instrAddr));

    pcTrack: assert property (@(posedge clk) disable iff (!arstN) instrAddr == refPc)
        else reportMismatch("pcTrack", $sampled(refPc), $sampled(instrAddr));

    seqFlow: assert property (@(posedge clk) disable iff (!arstN)
        !changesFlow(instr) |=> instrAddr == $past(instrAddr) + 32'd4)
        else reportMismatch("seqFlow", $past(instrAddr) + 32'd4, $sampled(instrAddr));

    storeAddr: assert property (@(posedge clk) disable iff (!arstN)
        memWrite |-> memAddr == expAddr)
        else reportMismatch("storeAddr", $sampled(expAddr), $sampled(memAddr));

    storeData: assert property (@(posedge clk) disable iff (!arstN)
        memWrite |-> memWData == expWData)
        else reportMismatch("storeData", $sampled(expWData), $sampled(memWData));

    storeStrobe: assert property (@(posedge clk) disable iff (!arstN)
        instr[31:26] == `OP_SW |-> memWrite)
        else begin
            errors++;
            $display("store at pc %h did not raise memWrite", $sampled(instrAddr));
        end

    loadAddr: assert property (@(posedge clk) disable iff (!arstN)
        instr[31:26] == `OP_LW |-> memRead && memAddr == expAddr)
        else reportMismatch("loadAddr", $sampled(expAddr), $sampled(memAddr));

    unknownIdle: assert property (@(posedge clk) disable iff (!arstN) isUnknownOp(instr)
        |-> !memRead && !memWrite && !u_mipsCore.u_regFile.writeEnable)
        else begin
            errors++;
            $display("unknown opcode at pc %h caused a write or a read", $sampled(instrAddr));
        end

    initial
    begin
        arstN <= 1'b0;
        loadProgram();
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        while (instrAddr !== HALT_ADDR && cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        repeat (2) @(posedge clk); // let the last checks sample
        if (cycles >= CYCLE_LIMIT)
        begin
            errors++;
            $display("timeout: the core never reached the halt loop at %h", HALT_ADDR);
        end
        $display("errors: %0d after %0d cycles", errors, cycles);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
